// ==== bench/heapTb.sv ====
// --------------------------------------------------------------------------
// Heap testbench: directed sequences and an LFSR command stream, each
// result checked against a reference model of the heap
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "heap_macros.svh"

module heapTb;
  import heapPkg::*;

  typedef logic [`HEAP_DATA_BITS-1:0] dataWord_t;

  localparam int Arrays           = 1 << `HEAP_ARRAY_BITS;
  localparam int Length           = 1 << `HEAP_INDEX_BITS;
  localparam int FillCommands     = Arrays + Arrays * Length + 1;
  localparam int DirectedCommands = 60;
  localparam int RandomCommands   = 400;
  localparam int CycleLimit       = FillCommands + DirectedCommands + RandomCommands + 20;

  logic        clock = 1'b0;
  logic        resetN;
  logic        commandValid;
  heapCmd_t    command;
  heapResult_t result;

  heapResult_t expected [$];                     // Predictions in issue order
  heapResult_t wanted;
  int          cycles = 0;
  logic [15:0] lfsr;

  // Reference model state
  logic        modelAllocated [Arrays];
  int          modelSize [Arrays];
  int          modelFree [$];                    // Newest freed at the back
  int          modelNext;
  dataWord_t   modelElement [Arrays][Length];

  heapTop dut_i (
    .clock        (clock),
    .resetN       (resetN),
    .commandValid (commandValid),
    .command      (command),
    .result       (result)
  );

  always #4 clock = ~clock;

  task automatic failRun(input string reason);
    $display("%s", reason);
    $display("tests failed");
    $fatal(1, "run stopped on first error");
  endtask

  // Galois LFSR, taps 16 14 13 11, one step per bit taken
  function automatic logic [15:0] nextBits(input int count);
    logic [15:0] bits;
    bits = '0;
    for (int i = 0; i < count; i++) begin
      bits = {bits[14:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return bits;
  endfunction

  // ------------------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------------------
  function automatic heapResult_t predict(input heapCmd_t cmd);
    heapResult_t r;
    int          a;
    int          idx;
    int          sz;
    dataWord_t   old;
    dataWord_t   updated;
    a   = int'(cmd.array);
    idx = int'(cmd.index);
    sz  = modelSize[a];
    old = modelElement[a][idx];
    r   = '{valid: 1'b1, data: '0, error: noError};
    case (cmd.op)
      nop: ;
      clear: begin
        foreach (modelAllocated[i]) modelAllocated[i] = 1'b0;
        modelFree.delete();
        modelNext = 0;
      end
      alloc: begin
        if (modelFree.size() != 0) begin
          a = modelFree.pop_back();              // Newest freed first
        end else if (modelNext < Arrays) begin
          a = modelNext;
          modelNext++;
        end else begin
          r.error = outOfMemory;
        end
        if (r.error == noError) begin
          modelAllocated[a] = 1'b1;
          modelSize[a]      = 0;
          r.data            = dataWord_t'(a);
        end
      end
      default: begin
        if (!modelAllocated[a]) begin
          r.error = notAllocated;
        end else begin
          case (cmd.op)
            free: begin
              modelAllocated[a] = 1'b0;
              modelFree.push_back(a);
            end
            write: begin
              modelElement[a][idx] = cmd.data;
              if (idx >= sz) modelSize[a] = idx + 1;
              r.data = cmd.data;
            end
            size: r.data = dataWord_t'(sz);
            push: begin
              if (sz == Length) begin
                r.error = arrayFull;
              end else begin
                modelElement[a][sz] = cmd.data;
                modelSize[a]        = sz + 1;
                r.data              = cmd.data;
              end
            end
            pop: begin
              if (sz == 0) begin
                r.error = arrayEmpty;
              end else begin
                modelSize[a] = sz - 1;
                r.data       = modelElement[a][sz - 1];
              end
            end
            default: begin                       // Read and element arithmetic
              if (idx >= sz) begin
                r.error = outOfBounds;
              end else begin
                case (cmd.op)
                  add, addAfter: updated = old + cmd.data;
                  sub, subAfter: updated = old - cmd.data;
                  orOp:          updated = old | cmd.data;
                  xorOp:         updated = old ^ cmd.data;
                  andOp:         updated = old & cmd.data;
                  default:       updated = old;
                endcase
                modelElement[a][idx] = updated;
                r.data = (cmd.op inside {read, addAfter, subAfter}) ? old : updated;
              end
            end
          endcase
        end
      end
    endcase
    return r;
  endfunction

  // ------------------------------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------------------------------
  task automatic sendCommand(input heapOp_t op, input int array, input int index,
                             input int data);
    heapCmd_t cmd;
    cmd.op       = op;
    cmd.array    = array[`HEAP_ARRAY_BITS-1:0];
    cmd.index    = index[`HEAP_INDEX_BITS-1:0];
    cmd.data     = data[`HEAP_DATA_BITS-1:0];
    command      = cmd;
    commandValid = 1'b1;
    expected.push_back(predict(cmd));
    @(posedge clock);
    #1;
  endtask

  task automatic directedStep(input heapOp_t op, input int array, input int index,
                              input int data, input int wantData,
                              input heapError_t wantError);
    heapResult_t last;
    sendCommand(op, array, index, data);
    last = expected[expected.size() - 1];
    assert (last.data == dataWord_t'(wantData) && last.error == wantError) else
      failRun($sformatf("MISMATCH at %0t: op %0d predicted data %h error %0d, want %h %0d",
                        $time, op, last.data, last.error, wantData, wantError));
  endtask

  // Every element gets a value built from its whole address
  task automatic fillElements();
    for (int a = 0; a < Arrays; a++) sendCommand(alloc, 0, 0, 0);
    for (int a = 0; a < Arrays; a++) begin
      for (int i = 0; i < Length; i++) begin
        sendCommand(write, a, i, {a[`HEAP_ARRAY_BITS-1:0], i[`HEAP_INDEX_BITS-1:0],
                                  ~a[`HEAP_ARRAY_BITS-1:0], ~i[`HEAP_INDEX_BITS-1:0]});
      end
    end
    sendCommand(clear, 0, 0, 0);
  endtask

  function automatic int pickArray();
    int start;
    start = int'(nextBits(`HEAP_ARRAY_BITS));
    if (nextBits(2) != 0) begin                  // Three in four aim at a live array
      for (int k = 0; k < Arrays; k++) begin
        if (modelAllocated[(start + k) % Arrays]) return (start + k) % Arrays;
      end
    end
    return start;
  endfunction

  // ------------------------------------------------------------------------
  // Compare and timeout
  // ------------------------------------------------------------------------
  always @(negedge clock) begin
    if (resetN && result.valid) begin
      if (expected.size() == 0) begin
        failRun("result valid with no command outstanding");
      end else begin
        wanted = expected.pop_front();
        assert (result.data === wanted.data && result.error === wanted.error) else
          failRun($sformatf("MISMATCH at %0t: data %h error %0d, expected %h error %0d",
                            $time, result.data, result.error, wanted.data, wanted.error));
      end
    end
  end

  always @(posedge clock) begin
    if (resetN) begin
      cycles = cycles + 1;
      if (cycles > CycleLimit) failRun($sformatf("timeout after %0d cycles", cycles));
    end
  end

  initial begin : stimulus
    heapOp_t     op;
    logic [15:0] opBits;
    int          array;
    int          index;
    int          data;
    resetN       = 1'b0;
    commandValid = 1'b0;
    command      = '0;
    lfsr         = 16'd9;
    modelNext    = 0;
    foreach (modelAllocated[i]) begin
      modelAllocated[i] = 1'b0;
      modelSize[i]      = 0;
    end
    repeat (3) @(posedge clock);
    #1 resetN = 1'b1;

    directedStep(read, 3, 0, 0, 0, notAllocated);  // Never allocated
    fillElements();

    // Alloc order, reuse and out of memory
    for (int i = 0; i < 3; i++) directedStep(alloc, 0, 0, 0, i, noError);
    directedStep(free, 2, 0, 0, 0, noError);
    directedStep(alloc, 0, 0, 0, 2, noError);
    for (int i = 3; i < Arrays; i++) directedStep(alloc, 0, 0, 0, i, noError);
    directedStep(alloc, 0, 0, 0, 0, outOfMemory);

    // Write, read, bounds and growth
    directedStep(write, 0, 2, 'h123, 'h123, noError);
    directedStep(read,  0, 2, 0, 'h123, noError);
    directedStep(read,  0, 3, 0, 0, outOfBounds);
    directedStep(size,  0, 0, 0, 3, noError);
    directedStep(write, 0, 6, 'h456, 'h456, noError);
    directedStep(size,  0, 0, 0, 7, noError);
    directedStep(read,  0, 7, 0, 0, outOfBounds);

    // Stack on array 1
    for (int i = 0; i < Length; i++) directedStep(push, 1, 0, 'h100 + i, 'h100 + i, noError);
    directedStep(push, 1, 0, 'h1ff, 0, arrayFull);
    directedStep(size, 1, 0, 0, Length, noError);
    for (int i = Length - 1; i >= 0; i--) directedStep(pop, 1, 0, 0, 'h100 + i, noError);
    directedStep(pop, 1, 0, 0, 0, arrayEmpty);

    // Back-to-back read-modify-write, exercises forwarding
    directedStep(add,      0, 2, 'h005, 'h128, noError);
    directedStep(addAfter, 0, 2, 'h005, 'h128, noError);
    directedStep(sub,      0, 2, 'h010, 'h11d, noError);
    directedStep(subAfter, 0, 2, 'h020, 'h11d, noError);
    directedStep(orOp,     0, 2, 'hf00, 'hffd, noError);
    directedStep(xorOp,    0, 2, 'h0ff, 'hf02, noError);
    directedStep(andOp,    0, 2, 'h0f0, 'h000, noError);
    directedStep(sub,      0, 2, 'h001, 'hfff, noError);
    directedStep(read,     0, 2, 0, 'hfff, noError);

    // Freed arrays and clear
    directedStep(free,  2, 0, 0, 0, noError);
    directedStep(free,  2, 0, 0, 0, notAllocated);
    directedStep(read,  2, 0, 0, 0, notAllocated);
    directedStep(write, 2, 0, 'h777, 0, notAllocated);
    directedStep(push,  2, 0, 'h777, 0, notAllocated);
    directedStep(size,  2, 0, 0, 0, notAllocated);
    directedStep(clear, 0, 0, 0, 0, noError);
    directedStep(size,  0, 0, 0, 0, notAllocated);
    directedStep(read,  5, 0, 0, 0, notAllocated);
    directedStep(alloc, 0, 0, 0, 0, noError);
    directedStep(size,  0, 0, 0, 0, noError);
    directedStep(alloc, 0, 0, 0, 1, noError);
    directedStep(alloc, 0, 0, 0, 2, noError);

    // LFSR command stream
    for (int n = 0; n < RandomCommands; n++) begin
      opBits = nextBits(4);
      op     = heapOp_t'(opBits[3:0]);
      if (op == clear && nextBits(2) != 0) op = read;  // Keep clears rare
      array = pickArray();
      index = int'(nextBits(`HEAP_INDEX_BITS));
      data  = int'(nextBits(`HEAP_DATA_BITS));
      sendCommand(op, array, index, data);
    end
    commandValid = 1'b0;

    repeat (3) @(posedge clock);                 // Fixed pipeline latency
    if (expected.size() != 0) begin
      failRun($sformatf("%0d results never arrived", expected.size()));
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

// ==== bench/heap_checker.sv ====
// --------------------------------------------------------------------------
// Heap pipeline checker for result valid timing and clean write-back
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module heapChecker (
  input logic                 clock,
  input logic                 resetN,
  input logic                 commandValid,
  input heapPkg::heapResult_t result,
  input logic                 writeEnable
);
  import heapPkg::*;

  resultQuietInReset: assert property (
    @(posedge clock) !resetN |-> !result.valid
  ) else $error("result valid high during reset");

  // Each command gives one result three edges later
  resultLatency: assert property (
    @(posedge clock) disable iff (!resetN)
      result.valid == $past(commandValid, 3)
  ) else $error("result valid does not follow command valid by three cycles");

  // The written command reaches the result port on the next edge
  cleanWriteBack: assert property (
    @(posedge clock) disable iff (!resetN)
      writeEnable |=> (result.valid && (result.error == noError))
  ) else $error("write-back for a command with an error");

endmodule

bind heapTop heapChecker checker_i (
  .clock        (clock),
  .resetN       (resetN),
  .commandValid (commandValid),
  .result       (result),
  .writeEnable  (writeEnable)
);

// ==== filelist.f ====
+incdir+include
rtl/heapPkg.sv
rtl/heapCheck.sv
rtl/heapFetch.sv
rtl/heapAlu.sv
rtl/heapTop.sv
bench/heap_checker.sv
bench/heapTb.sv

// ==== include/heap_macros.svh ====
// --------------------------------------------------------------------------
// Heap widths shared by the package, the pipeline stages and the testbench
// Array number, element index and element data sizes
// --------------------------------------------------------------------------
`ifndef HEAP_MACROS_SVH
`define HEAP_MACROS_SVH

// --------------------------------------------------------------------------
// Addressing
// --------------------------------------------------------------------------
`define HEAP_ARRAY_BITS 3                 // 8 arrays
`define HEAP_INDEX_BITS 3                 // Up to 8 elements per array

// --------------------------------------------------------------------------
// Payload
// --------------------------------------------------------------------------
`define HEAP_DATA_BITS 12                 // Element width

// Sizes carry one extra bit so a full array can count to 8
// and the allocator can count all 8 arrays handed out

`endif

// ==== rtl/heapAlu.sv ====
// --------------------------------------------------------------------------
// Heap stage three: new element value, write-back and result selection
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "heap_macros.svh"

module heapAlu (
  input  logic                         clock,
  input  logic                         resetN,
  input  heapPkg::fetchedCmd_t         fetched,
  output logic                         writeEnable,
  output logic [`HEAP_ARRAY_BITS-1:0]  writeArray,
  output logic [`HEAP_INDEX_BITS-1:0]  writeIndex,
  output logic [`HEAP_DATA_BITS-1:0]   writeData,
  output heapPkg::heapResult_t         result
);
  import heapPkg::*;

  logic [`HEAP_DATA_BITS-1:0] element;
  logic [`HEAP_DATA_BITS-1:0] operand;
  logic [`HEAP_DATA_BITS-1:0] newValue;
  logic [`HEAP_DATA_BITS-1:0] resultData;
  logic                       writesBack;
  logic                       clean;

  assign element = fetched.element;
  assign operand = fetched.cmd.data;
  assign clean   = fetched.cmd.valid && (fetched.cmd.error == noError);

  // ------------------------------------------------------------------------
  // Element update
  // ------------------------------------------------------------------------
  always_comb begin
    newValue   = operand;
    writesBack = 1'b1;
    case (fetched.cmd.op)
      write, push:   newValue = operand;
      add, addAfter: newValue = element + operand;
      sub, subAfter: newValue = element - operand;
      orOp:          newValue = element | operand;
      xorOp:         newValue = element ^ operand;
      andOp:         newValue = element & operand;
      default:       writesBack = 1'b0;                   // Pop only moves the size
    endcase
  end

  assign writeEnable = clean && writesBack;
  assign writeArray  = fetched.cmd.array;
  assign writeIndex  = fetched.cmd.index;
  assign writeData   = newValue;

  // ------------------------------------------------------------------------
  // Result selection
  // ------------------------------------------------------------------------
  always_comb begin
    case (fetched.cmd.op)
      write, push:                   resultData = operand;
      read, pop, addAfter, subAfter: resultData = element;    // Old value
      size, alloc:                   resultData = fetched.cmd.earlyResult;
      add, sub, orOp, xorOp, andOp:  resultData = newValue;
      default:                       resultData = '0;          // Nop, clear, free
    endcase
    if (fetched.cmd.error != noError) resultData = '0;
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      result <= '0;
    end else begin
      result <= '{valid: fetched.cmd.valid,
                  data:  resultData,
                  error: fetched.cmd.error};
    end
  end

endmodule

// ==== rtl/heapCheck.sv ====
// --------------------------------------------------------------------------
// Heap stage one: allocator, free stack, allocation flags and size table
// Classifies each command's error and updates the tables in the same cycle
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "heap_macros.svh"

module heapCheck (
  input  logic                 clock,
  input  logic                 resetN,
  input  logic                 commandValid,
  input  heapPkg::heapCmd_t    command,
  output heapPkg::checkedCmd_t checked
);
  import heapPkg::*;

  localparam int Arrays = 1 << `HEAP_ARRAY_BITS;

  logic [Arrays-1:0]             allocated;             // One flag per array
  logic [`HEAP_INDEX_BITS:0]     arraySize [Arrays];
  logic [`HEAP_ARRAY_BITS-1:0]   freeStack [Arrays];    // Freed arrays, newest on top
  logic [`HEAP_ARRAY_BITS:0]     freeTop;
  logic [`HEAP_ARRAY_BITS:0]     nextArray;             // Arrays handed out so far

  logic [`HEAP_INDEX_BITS:0]     curSize;
  logic [`HEAP_INDEX_BITS:0]     popSize;
  logic [`HEAP_INDEX_BITS:0]     wideIndex;
  logic [`HEAP_ARRAY_BITS:0]     freeTopDec;
  logic                          isAllocated;
  logic                          haveFreed;
  logic [`HEAP_ARRAY_BITS-1:0]   allocArray;
  heapError_t                    cmdError;
  logic [`HEAP_INDEX_BITS-1:0]   effIndex;
  logic [`HEAP_DATA_BITS-1:0]    earlyData;
  logic                          accept;

  // ------------------------------------------------------------------------
  // Classification
  // ------------------------------------------------------------------------
  always_comb begin
    curSize     = arraySize[command.array];
    popSize     = curSize - 1'b1;
    wideIndex   = {1'b0, command.index};
    freeTopDec  = freeTop - 1'b1;
    isAllocated = allocated[command.array];
    haveFreed   = (freeTop != '0);
    allocArray  = haveFreed ? freeStack[freeTopDec[`HEAP_ARRAY_BITS-1:0]]
                            : nextArray[`HEAP_ARRAY_BITS-1:0];

    cmdError = noError;
    case (command.op)
      nop, clear: cmdError = noError;
      alloc: begin
        if (!haveFreed && nextArray[`HEAP_ARRAY_BITS]) cmdError = outOfMemory;  // All 8 used
      end
      free, write, size: begin
        if (!isAllocated) cmdError = notAllocated;
      end
      push: begin
        if (!isAllocated) cmdError = notAllocated;
        else if (curSize[`HEAP_INDEX_BITS]) cmdError = arrayFull;
      end
      pop: begin
        if (!isAllocated) cmdError = notAllocated;
        else if (curSize == '0) cmdError = arrayEmpty;
      end
      default: begin                                      // Read and arithmetic
        if (!isAllocated) cmdError = notAllocated;
        else if (wideIndex >= curSize) cmdError = outOfBounds;
      end
    endcase

    case (command.op)
      push:    effIndex = curSize[`HEAP_INDEX_BITS-1:0];  // Old top
      pop:     effIndex = popSize[`HEAP_INDEX_BITS-1:0];  // New top
      default: effIndex = command.index;
    endcase

    earlyData = '0;
    if (command.op == alloc) earlyData[`HEAP_ARRAY_BITS-1:0] = allocArray;
    else if (command.op == size) earlyData[`HEAP_INDEX_BITS:0] = curSize;

    accept = commandValid && (cmdError == noError);
  end

  // ------------------------------------------------------------------------
  // Table updates, error-free commands only
  // ------------------------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocated <= '0;
      freeTop   <= '0;
      nextArray <= '0;
      for (int i = 0; i < Arrays; i++) begin
        arraySize[i] <= '0;
      end
    end else if (accept) begin
      case (command.op)
        clear: begin                                       // Sizes reset on next alloc
          allocated <= '0;
          freeTop   <= '0;
          nextArray <= '0;
        end
        alloc: begin
          allocated[allocArray] <= 1'b1;
          arraySize[allocArray] <= '0;
          if (haveFreed) freeTop <= freeTopDec;
          else nextArray <= nextArray + 1'b1;
        end
        free: begin
          allocated[command.array] <= 1'b0;
          freeTop                  <= freeTop + 1'b1;
        end
        write: begin
          if (wideIndex >= curSize) arraySize[command.array] <= wideIndex + 1'b1;  // Grow
        end
        push:    arraySize[command.array] <= curSize + 1'b1;
        pop:     arraySize[command.array] <= popSize;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (accept && command.op == free) begin
      freeStack[freeTop[`HEAP_ARRAY_BITS-1:0]] <= command.array;
    end
  end

  // Stage register
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      checked <= '0;
    end else begin
      checked <= '{valid:       commandValid,
                   op:          command.op,
                   array:       command.array,
                   index:       effIndex,
                   data:        command.data,
                   error:       cmdError,
                   earlyResult: earlyData};
    end
  end

endmodule

// ==== rtl/heapFetch.sv ====
// --------------------------------------------------------------------------
// Heap stage two: element memory of 8 arrays by 8 words
// Reads the addressed element, bypassing stage three's pending write
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "heap_macros.svh"

module heapFetch (
  input  logic                         clock,
  input  logic                         resetN,
  input  heapPkg::checkedCmd_t         checked,
  input  logic                         writeEnable,
  input  logic [`HEAP_ARRAY_BITS-1:0]  writeArray,
  input  logic [`HEAP_INDEX_BITS-1:0]  writeIndex,
  input  logic [`HEAP_DATA_BITS-1:0]   writeData,
  output heapPkg::fetchedCmd_t         fetched
);

  localparam int Arrays = 1 << `HEAP_ARRAY_BITS;
  localparam int Length = 1 << `HEAP_INDEX_BITS;

  logic [`HEAP_DATA_BITS-1:0] elements [Arrays][Length];  // Fixed block per array
  logic                       forward;
  logic [`HEAP_DATA_BITS-1:0] element;

  // ------------------------------------------------------------------------
  // Read with forwarding
  // ------------------------------------------------------------------------
  // Stage three writes at the coming edge, so a command one behind
  // it on the same element must see that value now
  assign forward = writeEnable
                && (writeArray == checked.array)
                && (writeIndex == checked.index);

  assign element = forward ? writeData
                           : elements[checked.array][checked.index];

  // ------------------------------------------------------------------------
  // Write port
  // ------------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (writeEnable) begin
      elements[writeArray][writeIndex] <= writeData;      // From stage three
    end
  end

  // ------------------------------------------------------------------------
  // Stage register
  // ------------------------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      fetched <= '0;                                      // Clears valid
    end else begin
      fetched <= '{cmd: checked, element: element};
    end
  end

endmodule

// ==== rtl/heapPkg.sv ====
// --------------------------------------------------------------------------
// Heap types: opcodes, error codes and the structs passed down the
// three-stage pipeline from command to result
// --------------------------------------------------------------------------
`include "heap_macros.svh"

package heapPkg;

  // ------------------------------------------------------------------------
  // Enumerations
  // ------------------------------------------------------------------------
  typedef enum logic [3:0] {
    nop      = 4'd0,                      // No operation
    clear    = 4'd1,                      // Release every array
    alloc    = 4'd2,                      // Returns new array number
    free     = 4'd3,                      // Newest freed is reused first
    write    = 4'd4,
    read     = 4'd5,
    size     = 4'd6,
    push     = 4'd7,
    pop      = 4'd8,
    add      = 4'd9,                      // Returns new value
    addAfter = 4'd10,                     // Returns old value
    sub      = 4'd11,
    subAfter = 4'd12,
    orOp     = 4'd13,
    xorOp    = 4'd14,
    andOp    = 4'd15
  } heapOp_t;

  typedef enum logic [2:0] {
    noError      = 3'd0,
    notAllocated = 3'd1,
    outOfBounds  = 3'd2,                  // Index at or past the size
    arrayFull    = 3'd3,
    arrayEmpty   = 3'd4,
    outOfMemory  = 3'd5
  } heapError_t;

  // ------------------------------------------------------------------------
  // Pipeline payloads
  // ------------------------------------------------------------------------
  typedef struct packed {
    heapOp_t                      op;
    logic [`HEAP_ARRAY_BITS-1:0]  array;
    logic [`HEAP_INDEX_BITS-1:0]  index;
    logic [`HEAP_DATA_BITS-1:0]   data;
  } heapCmd_t;

  typedef struct packed {
    logic                         valid;
    heapOp_t                      op;
    logic [`HEAP_ARRAY_BITS-1:0]  array;
    logic [`HEAP_INDEX_BITS-1:0]  index;       // Effective index
    logic [`HEAP_DATA_BITS-1:0]   data;
    heapError_t                   error;
    logic [`HEAP_DATA_BITS-1:0]   earlyResult; // Alloc array or size
  } checkedCmd_t;

  typedef struct packed {
    checkedCmd_t                  cmd;
    logic [`HEAP_DATA_BITS-1:0]   element;     // Value before the op
  } fetchedCmd_t;

  typedef struct packed {
    logic                         valid;
    logic [`HEAP_DATA_BITS-1:0]   data;
    heapError_t                   error;
  } heapResult_t;

endpackage

// ==== rtl/heapTop.sv ====
// --------------------------------------------------------------------------
// Pipelined heap top: check, fetch and ALU stages, three cycles latency
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "heap_macros.svh"

module heapTop (
  input  logic                 clock,
  input  logic                 resetN,
  input  logic                 commandValid,
  input  heapPkg::heapCmd_t    command,
  output heapPkg::heapResult_t result
);
  import heapPkg::*;

  checkedCmd_t                 checked;                   // Stage one to two
  fetchedCmd_t                 fetched;                   // Stage two to three
  logic                        writeEnable;               // Write-back, three to two
  logic [`HEAP_ARRAY_BITS-1:0] writeArray;
  logic [`HEAP_INDEX_BITS-1:0] writeIndex;
  logic [`HEAP_DATA_BITS-1:0]  writeData;

  heapCheck check_i (
    .clock        (clock),
    .resetN       (resetN),
    .commandValid (commandValid),
    .command      (command),
    .checked      (checked)
  );

  heapFetch fetch_i (
    .clock       (clock),
    .resetN      (resetN),
    .checked     (checked),
    .writeEnable (writeEnable),
    .writeArray  (writeArray),
    .writeIndex  (writeIndex),
    .writeData   (writeData),
    .fetched     (fetched)
  );

  heapAlu alu_i (
    .clock       (clock),
    .resetN      (resetN),
    .fetched     (fetched),
    .writeEnable (writeEnable),
    .writeArray  (writeArray),
    .writeIndex  (writeIndex),
    .writeData   (writeData),
    .result      (result)
  );

endmodule

// ==== run.sh ====
#!/bin/sh
# Build the heap testbench with Verilator and run it
# Exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module heapTb \
  -f filelist.f \
  --Mdir obj_dir -o heapTb
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/heapTb
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit "$status"
fi

exit 0
